/* Bender.yml */
package:
  name: decode_top

sources:
  - rv32i_types.sv
  - pipe_types.sv
  - fetch_unit.sv
  - pipeline_regfile.sv
  - id_stage.sv
  - decode_top.sv
  - target: simulation
    files:
      - tb_decode_top.sv

/* decode_cases.txt */
# inst we rd_w rd_v same | imm rd_s rs1_s rs2_s flags alu_op mul
# flags = regf_we mem_read mem_write branch jal jalr alu_src alu_or_cmp, mul = if_mul type half
123450b7 1 02 000000aa 0 12345000 01 00 00 83 0 0
fff10193 0 00 00000000 0 ffffffff 03 02 00 83 0 0
00510233 1 05 00000055 1 00000000 04 02 05 81 0 0
40228333 0 00 00000000 0 00000000 06 05 02 81 3 0
4022d3b3 0 00 00000000 0 00000000 07 05 02 81 2 0
0022d3b3 0 00 00000000 0 00000000 07 05 02 81 5 0
0022a433 0 00 00000000 0 00000000 08 05 02 80 4 0
00a2b493 0 00 00000000 0 0000000a 09 05 00 82 6 0
4032d513 0 00 00000000 0 00000003 0a 05 00 83 2 0
022285b3 0 00 00000000 0 00000000 0b 05 02 81 0 a
02229633 0 00 00000000 0 00000000 0c 05 02 81 0 b
0222b6b3 0 00 00000000 0 00000000 0d 05 02 81 0 9
00512423 1 00 00000099 0 00000008 00 02 05 23 0 0
fe22c8e3 1 02 00000077 1 fffffff0 00 05 02 10 4 0
ffc12703 0 00 00000000 0 fffffffc 0e 02 00 c3 0 0
001000ef 0 00 00000000 0 00000004 01 00 00 8b 0 0
00c201e7 1 04 00001234 0 00000004 03 04 00 87 0 0
fffff797 1 0f 00000005 1 fffff000 0f 00 00 83 0 0
0047c833 0 00 00000000 0 00000000 10 0f 04 81 4 0

/* decode_top.sv */
module decode_top #(
    parameter logic [31:0] RESET_PC = 32'h6000_0000
) (
    input  logic                   clk,
    input  logic                   arst_n,
    output pipe_types::wb_req_t    imem_req,
    input  pipe_types::wb_rsp_t    imem_rsp,
    input  pipe_types::rf_write_t  wb_write,
    input  logic                   ex_ready,
    output pipe_types::id_ex_reg_t id_ex_reg,
    output logic                   id_ex_valid
);

    import pipe_types::*;

    if_id_reg_t if_id_reg;
    logic       if_id_take;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_req   (imem_req),
        .imem_rsp   (imem_rsp),
        .if_id_take (if_id_take),
        .if_id_reg  (if_id_reg)
    );

    // decode owns the register file and the id/ex slot
    id_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .if_id_reg   (if_id_reg),
        .if_id_take  (if_id_take),
        .rf_write    (wb_write),
        .ex_ready    (ex_ready),
        .id_ex_reg   (id_ex_reg),
        .id_ex_valid (id_ex_valid)
    );

endmodule

/* fetch_unit.sv */
module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h6000_0000
) (
    input  logic                   clk,
    input  logic                   arst_n,
    output pipe_types::wb_req_t    imem_req,
    input  pipe_types::wb_rsp_t    imem_rsp,
    input  logic                   if_id_take,
    output pipe_types::if_id_reg_t if_id_reg
);

    typedef enum logic {
        st_idle,
        st_wait
    } state_t;

    state_t      state;
    logic [31:0] pc;
    logic        if_id_valid;
    logic [31:0] if_id_pc;
    logic [31:0] if_id_inst;
    logic        can_start;

    // slot empty, or decode drains it this cycle
    assign can_start = !if_id_valid || if_id_take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            pc    <= RESET_PC;
        end else begin
            case (state)
                st_idle: begin
                    if (can_start) state <= st_wait;
                end
                st_wait: begin
                    if (imem_rsp.ack) begin
                        state <= st_idle; // bus idles one cycle
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_valid <= 1'b0;
        end else if (state == st_wait && imem_rsp.ack) begin
            if_id_valid <= 1'b1;
        end else if (if_id_take) begin
            if_id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait && imem_rsp.ack) begin
            if_id_pc   <= pc;
            if_id_inst <= imem_rsp.dat;
        end
    end

    assign imem_req.cyc = (state == st_wait);
    assign imem_req.stb = (state == st_wait);
    assign imem_req.we  = 1'b0;
    assign imem_req.adr = pc;
    assign imem_req.sel = 4'hf;

    assign if_id_reg.pc    = if_id_pc;
    assign if_id_reg.inst  = if_id_inst;
    assign if_id_reg.valid = if_id_valid;

    a_adr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (imem_req.stb && !imem_rsp.ack) |=> $stable(imem_req.adr));

    // no fetch runs while the if/id register still holds a word
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req.stb |-> (imem_req.cyc && !if_id_valid));

endmodule

/* id_stage.sv */
module id_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  pipe_types::if_id_reg_t if_id_reg,
    output logic                   if_id_take,
    input  pipe_types::rf_write_t  rf_write,
    input  logic                   ex_ready,
    output pipe_types::id_ex_reg_t id_ex_reg,
    output logic                   id_ex_valid
);

    import rv32i_types::*;
    import pipe_types::*;

    inst_u       w;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1_s;
    logic [4:0]  rs2_s;
    logic [31:0] rs1_rf;
    logic [31:0] rs2_rf;

    logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [31:0] imm;

    logic        writeback, mem_read, mem_write, branch, jal, jalr, alu_src, calu;
    alu_ops_t    aluop;
    logic        mul, mul_h;
    logic [1:0]  m_type;

    id_ex_reg_t  id_ex_next;
    logic        load;

    assign w      = if_id_reg.inst;
    assign opcode = w.r.opcode;
    assign funct3 = w.r.funct3;
    assign funct7 = w.r.funct7;

    // unused sources read x0
    always_comb begin
        case (opcode)
            op_b_lui, op_b_auipc, op_b_jal: begin
                rs1_s = '0;
                rs2_s = '0;
            end
            op_b_jalr, op_b_load, op_b_imm: begin
                rs1_s = w.r.rs1;
                rs2_s = '0;
            end
            default: begin
                rs1_s = w.r.rs1;
                rs2_s = w.r.rs2;
            end
        endcase
    end

    always_comb begin
        s_imm = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
        b_imm = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
        u_imm = {w.u.imm, 12'h000};
        j_imm = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
        if (opcode == op_b_imm && funct3 == sr) begin
            i_imm = {{27{w.i.imm[11]}}, w.r.rs2}; // shamt only
        end else begin
            i_imm = {{20{w.i.imm[11]}}, w.i.imm};
        end

        case (opcode)
            op_b_lui, op_b_auipc:          imm = u_imm;
            op_b_jal, op_b_jalr:           imm = 32'h4; // link offset
            op_b_br:                       imm = b_imm;
            op_b_load, op_b_imm, op_b_csr: imm = i_imm;
            op_b_store:                    imm = s_imm;
            default:                       imm = '0;
        endcase
    end

    always_comb begin
        writeback = opcode inside {op_b_lui, op_b_auipc, op_b_jal, op_b_jalr,
                                   op_b_load, op_b_imm, op_b_reg, op_b_atom};
        alu_src   = opcode inside {op_b_lui, op_b_auipc, op_b_jal, op_b_jalr,
                                   op_b_load, op_b_store, op_b_imm, op_b_atom};
        mem_read  = (opcode == op_b_load);
        mem_write = (opcode == op_b_store);
        branch    = (opcode == op_b_br);
        jal       = (opcode == op_b_jal);
        jalr      = (opcode == op_b_jalr);

        calu   = 1'b1;
        aluop  = alu_add;
        mul    = 1'b0;
        mul_h  = 1'b0;
        m_type = 2'b00;

        case (opcode)
            op_b_br: begin
                calu  = 1'b0;
                aluop = funct3; // branch funct3 is the cmp code
            end
            op_b_imm, op_b_reg: begin
                if (opcode == op_b_reg && funct7[0]) begin
                    mul = 1'b1;
                    case (funct3)
                        add:  m_type = 2'b01;
                        sll: begin
                            m_type = 2'b01;
                            mul_h  = 1'b1;
                        end
                        slt: begin
                            m_type = 2'b10; // mulhsu
                            mul_h  = 1'b1;
                        end
                        sltu: mul_h = 1'b1;
                        default: begin
                            mul   = 1'b0; // div and rem not decoded
                            aluop = funct3;
                        end
                    endcase
                end else begin
                    case (funct3)
                        slt: begin
                            calu  = 1'b0;
                            aluop = blt;
                        end
                        sltu: begin
                            calu  = 1'b0;
                            aluop = bltu;
                        end
                        sr:  aluop = funct7[5] ? alu_sra : alu_srl;
                        add: aluop = (opcode == op_b_reg && funct7[5]) ? alu_sub : alu_add;
                        default: aluop = funct3;
                    endcase
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        id_ex_next.pc         = if_id_reg.pc;
        id_ex_next.opcode     = opcode;
        id_ex_next.funct3     = funct3;
        id_ex_next.funct7     = funct7;
        id_ex_next.funct7_bit = funct7[5];
        id_ex_next.rd_s       = (opcode == op_b_store || opcode == op_b_br) ? 5'd0 : w.r.rd;
        id_ex_next.rs1_s      = rs1_s;
        id_ex_next.rs2_s      = rs2_s;
        // same-cycle writeback wins over the array
        id_ex_next.rs1_v = (rf_write.we && rf_write.rd_s != 5'd0 && rf_write.rd_s == rs1_s)
                           ? rf_write.rd_v : rs1_rf;
        id_ex_next.rs2_v = (rf_write.we && rf_write.rd_s != 5'd0 && rf_write.rd_s == rs2_s)
                           ? rf_write.rd_v : rs2_rf;
        id_ex_next.imm        = imm;
        id_ex_next.jalr_imm   = i_imm;
        id_ex_next.jal_imm    = j_imm;
        id_ex_next.regf_we    = writeback;
        id_ex_next.mem_read   = mem_read;
        id_ex_next.mem_write  = mem_write;
        id_ex_next.branch     = branch;
        id_ex_next.jal        = jal;
        id_ex_next.jalr       = jalr;
        id_ex_next.alu_src    = alu_src;
        id_ex_next.alu_or_cmp = calu;
        id_ex_next.alu_op     = aluop;
        id_ex_next.if_mul     = mul;
        id_ex_next.mul_type   = m_type;
        id_ex_next.half       = mul_h;
    end

    pipeline_regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rf_write (rf_write),
        .rs1_s    (rs1_s),
        .rs2_s    (rs2_s),
        .rs1_v    (rs1_rf),
        .rs2_v    (rs2_rf)
    );

    assign load       = if_id_reg.valid && (!id_ex_valid || ex_ready);
    assign if_id_take = load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex_valid <= 1'b0;
        end else if (load) begin
            id_ex_valid <= 1'b1;
        end else if (ex_ready) begin
            id_ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) id_ex_reg <= id_ex_next;
    end

    a_slot_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (id_ex_valid && !ex_ready) |=> (id_ex_valid && $stable(id_ex_reg)));

    a_known_op: assert property (@(posedge clk) disable iff (!arst_n)
        if_id_take |-> opcode inside {op_b_lui, op_b_auipc, op_b_jal, op_b_jalr,
            op_b_br, op_b_load, op_b_store, op_b_imm, op_b_reg, op_b_csr, op_b_atom});

endmodule

/* list.f */
rv32i_types.sv
pipe_types.sv
fetch_unit.sv
pipeline_regfile.sv
id_stage.sv
decode_top.sv
tb_decode_top.sv

/* pipe_types.sv */
package pipe_types;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        valid;
    } if_id_reg_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic        funct7_bit;
        logic [4:0]  rd_s;
        logic [4:0]  rs1_s;
        logic [4:0]  rs2_s;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] imm;
        logic [31:0] jalr_imm;
        logic [31:0] jal_imm;
        logic        regf_we;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jal;
        logic        jalr;
        logic        alu_src;    // 1 selects imm
        logic        alu_or_cmp; // 0 cmp, 1 alu
        logic [2:0]  alu_op;
        logic        if_mul;
        logic [1:0]  mul_type;
        logic        half;       // upper half of product
    } id_ex_reg_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd_s;
        logic [31:0] rd_v;
    } rf_write_t;

endpackage

/* pipeline_regfile.sv */
module pipeline_regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  pipe_types::rf_write_t rf_write,
    input  logic [4:0]            rs1_s,
    input  logic [4:0]            rs2_s,
    output logic [31:0]           rs1_v,
    output logic [31:0]           rs2_v
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write.we && rf_write.rd_s != 5'd0) begin
            regs[rf_write.rd_s] <= rf_write.rd_v;
        end
    end

    // x0 hardwired
    always_comb begin
        if (rs1_s == 5'd0) begin
            rs1_v = '0;
        end else begin
            rs1_v = regs[rs1_s];
        end
    end

    always_comb begin
        if (rs2_s == 5'd0) begin
            rs2_v = '0;
        end else begin
            rs2_v = regs[rs2_s];
        end
    end

endmodule

/* rv32i_types.sv */
package rv32i_types;

    // major opcodes
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011,
        op_b_csr   = 7'b1110011,
        op_b_atom  = 7'b0101111
    } opcode_t;

    // arithmetic funct3
    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // srl or sra by funct7[5]
        aor  = 3'b110,
        aand = 3'b111
    } funct3_t;

    // alu and compare codes share the 3 bit field
    typedef logic [2:0] alu_ops_t;

    localparam alu_ops_t alu_add = 3'b000;
    localparam alu_ops_t alu_sll = 3'b001;
    localparam alu_ops_t alu_sra = 3'b010;
    localparam alu_ops_t alu_sub = 3'b011;
    localparam alu_ops_t alu_xor = 3'b100;
    localparam alu_ops_t alu_srl = 3'b101;
    localparam alu_ops_t alu_or  = 3'b110;
    localparam alu_ops_t alu_and = 3'b111;
    localparam alu_ops_t blt     = 3'b100; // cmp unit codes
    localparam alu_ops_t bltu    = 3'b110;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage

/* tb_decode_top.sv */
module tb_decode_top;

    import rv32i_types::*;
    import pipe_types::*;

    localparam int          PERIOD    = 100;
    localparam int          MAX_CASES = 64;
    localparam logic [31:0] BASE_PC   = 32'h0000_1000;

    logic       clk;
    logic       arst_n;
    wb_req_t    imem_req;
    wb_rsp_t    imem_rsp;
    rf_write_t  wb_write;
    logic       ex_ready;
    id_ex_reg_t id_ex_reg;
    logic       id_ex_valid;

    // one row of the data file
    logic [31:0] c_inst  [MAX_CASES];
    logic        c_we    [MAX_CASES];
    logic [4:0]  c_rd_w  [MAX_CASES];
    logic [31:0] c_rd_v  [MAX_CASES];
    logic        c_same  [MAX_CASES];
    logic [31:0] c_imm   [MAX_CASES];
    logic [4:0]  c_rd_s  [MAX_CASES];
    logic [4:0]  c_rs1_s [MAX_CASES];
    logic [4:0]  c_rs2_s [MAX_CASES];
    logic [7:0]  c_flags [MAX_CASES];
    logic [2:0]  c_alu   [MAX_CASES];
    logic [3:0]  c_mul   [MAX_CASES];

    logic [31:0] exp_rs1_v [MAX_CASES];
    logic [31:0] exp_rs2_v [MAX_CASES];
    logic        pre_done  [MAX_CASES];
    logic [31:0] shadow    [32];

    int          n_cases;
    logic        cases_loaded;
    int          take_count;
    int          out_count;
    int          wait_cnt;
    logic [31:0] rng;

    decode_top #(
        .RESET_PC (BASE_PC)
    ) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_req    (imem_req),
        .imem_rsp    (imem_rsp),
        .wb_write    (wb_write),
        .ex_ready    (ex_ready),
        .id_ex_reg   (id_ex_reg),
        .id_ex_valid (id_ex_valid)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    cnt;
        string line;
        fd      = $fopen("decode_cases.txt", "r");
        n_cases = 0;
        if (fd == 0) begin
            $display("could not open decode_cases.txt");
            $display("TESTS FAILED");
            $fatal(1);
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                          c_inst[n_cases], c_we[n_cases], c_rd_w[n_cases],
                          c_rd_v[n_cases], c_same[n_cases], c_imm[n_cases],
                          c_rd_s[n_cases], c_rs1_s[n_cases], c_rs2_s[n_cases],
                          c_flags[n_cases], c_alu[n_cases], c_mul[n_cases]);
            if (cnt == 12) n_cases++;
        end
        $fclose(fd);
    endtask

    // write lands at the next edge, and the bypass makes it visible now
    task automatic apply_write(input int k);
        wb_write.we   = c_we[k];
        wb_write.rd_s = c_rd_w[k];
        wb_write.rd_v = c_rd_v[k];
        if (c_we[k] && c_rd_w[k] != 5'd0) shadow[c_rd_w[k]] = c_rd_v[k];
    endtask

    task automatic serve_memory();
        int idx;
        if (imem_req.stb) begin
            check_value("wb_cyc", 32'(imem_req.cyc), 32'd1);
            check_value("wb_we", 32'(imem_req.we), 32'd0);
            check_value("wb_sel", 32'(imem_req.sel), 32'hf);
            if (wait_cnt == 0) begin
                idx          = (imem_req.adr - BASE_PC) >> 2;
                imem_rsp.ack = 1'b1;
                imem_rsp.dat = (idx < n_cases) ? c_inst[idx] : 32'h0000_0013; // nop past end
                rng          = lcg_next(rng);
                wait_cnt     = rng[17:16];
            end else begin
                wait_cnt--;
            end
        end
    endtask

    // shift-immediate words carry only the shamt
    function automatic logic [31:0] i_imm_of(input logic [31:0] inst);
        if (inst[6:0] == 7'b0010011 && inst[14:12] inside {3'b001, 3'b101}) begin
            return {27'd0, inst[24:20]};
        end
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [31:0] j_imm_of(input logic [31:0] inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    task automatic record_take();
        int k;
        k = take_count;
        if (k < n_cases) begin
            if (c_same[k]) begin
                apply_write(k);
            end else if (!pre_done[k]) begin
                $display("word %0d was decoded before its register write was applied", k);
                $display("TESTS FAILED");
                $fatal(1);
            end
            exp_rs1_v[k] = (c_rs1_s[k] == 5'd0) ? 32'd0 : shadow[c_rs1_s[k]];
            exp_rs2_v[k] = (c_rs2_s[k] == 5'd0) ? 32'd0 : shadow[c_rs2_s[k]];
        end
        take_count++;
    endtask

    task automatic check_output(input int k);
        inst_u w;
        w = c_inst[k];
        $display("case %0d op %b rd %0d rs1 %0d rs2 %0d", k, w.r.opcode, w.r.rd, w.r.rs1,
                 w.r.rs2);
        check_value("pc", id_ex_reg.pc, BASE_PC + 32'(4 * k));
        check_value("opcode", 32'(id_ex_reg.opcode), 32'(c_inst[k][6:0]));
        check_value("funct3", 32'(id_ex_reg.funct3), 32'(c_inst[k][14:12]));
        check_value("funct7", 32'(id_ex_reg.funct7), 32'(c_inst[k][31:25]));
        check_value("funct7_bit", 32'(id_ex_reg.funct7_bit), 32'(c_inst[k][30]));
        check_value("imm", id_ex_reg.imm, c_imm[k]);
        check_value("jalr_imm", id_ex_reg.jalr_imm, i_imm_of(c_inst[k]));
        check_value("jal_imm", id_ex_reg.jal_imm, j_imm_of(c_inst[k]));
        check_value("rd_s", 32'(id_ex_reg.rd_s), 32'(c_rd_s[k]));
        check_value("rs1_s", 32'(id_ex_reg.rs1_s), 32'(c_rs1_s[k]));
        check_value("rs2_s", 32'(id_ex_reg.rs2_s), 32'(c_rs2_s[k]));
        check_value("rs1_v", id_ex_reg.rs1_v, exp_rs1_v[k]);
        check_value("rs2_v", id_ex_reg.rs2_v, exp_rs2_v[k]);
        check_value("flags", 32'({id_ex_reg.regf_we, id_ex_reg.mem_read, id_ex_reg.mem_write,
                                  id_ex_reg.branch, id_ex_reg.jal, id_ex_reg.jalr,
                                  id_ex_reg.alu_src, id_ex_reg.alu_or_cmp}),
                    32'(c_flags[k]));
        check_value("alu_op", 32'(id_ex_reg.alu_op), 32'(c_alu[k]));
        check_value("mul", 32'({id_ex_reg.if_mul, id_ex_reg.mul_type, id_ex_reg.half}),
                    32'(c_mul[k]));
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        imem_rsp     = '0;
        wb_write     = '0;
        ex_ready     = 1'b0;
        cases_loaded = 1'b0;
        take_count   = 0;
        out_count    = 0;
        wait_cnt     = 0;
        rng          = 32'hb2e;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        for (int i = 0; i < MAX_CASES; i++) pre_done[i] = 1'b0;
        load_cases();
        cases_loaded = 1'b1;

        repeat (2) @(posedge clk);
        #10 arst_n = 1'b1;

        while (out_count < n_cases) begin
            @(posedge clk);
            #10;
            rng          = lcg_next(rng);
            ex_ready     = (rng[29:28] != 2'b00); // low about one cycle in four
            imem_rsp.ack = 1'b0;
            wb_write.we  = 1'b0;
            #1;
            serve_memory();
            if (UUT.if_id_take) begin
                record_take();
            end else if (take_count < n_cases && !c_same[take_count]
                         && !pre_done[take_count]) begin
                apply_write(take_count);
                pre_done[take_count] = 1'b1;
            end
            if (id_ex_valid && ex_ready) begin
                check_output(out_count);
                out_count++;
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        wait (cases_loaded);
        #(n_cases * 20 * PERIOD);
        $display("decode outputs stopped arriving, %0d of %0d seen", out_count, n_cases);
        $display("TESTS FAILED");
        $fatal(1);
    end

endmodule
